// File: testbench/fir_patterns.txt
// hex words: run count, then per run tap count, data length, coefficients h[0]..h[taps-1],
// then one line per sample with the input sample and the expected output
4
1 4
3
5 f
7 15
10 30
2 6
5 8
1 2 ffffffff 0 10
1 1
2 4
3 6
4 8
5 1a
6 2c
7 3e
8 50
20 6
1 2 3 4 5 6 7 8
9 a b c d e f 10
11 12 13 14 15 16 17 18
19 1a 1b 1c 1d 1e 1f 20
1 1
2 4
3 a
4 14
5 23
6 38
5 3
2 2 2 2 2
1 2
1 4
1 6

// File: tb.f
hw/fir_regs_pkg.sv
hw/fir_core_pkg.sv
hw/fir_axil_regs.sv
hw/fir_sample_history.sv
hw/fir_mac_engine.sv
hw/fir_top.sv
testbench/tb_fir.sv

// File: Bender.yml
package:
  name: fir_stream

sources:
  - files:
      - hw/fir_regs_pkg.sv
      - hw/fir_core_pkg.sv
      - hw/fir_axil_regs.sv
      - hw/fir_sample_history.sv
      - hw/fir_mac_engine.sv
      - hw/fir_top.sv
  - target: test
    files:
      - testbench/tb_fir.sv

// File: testbench/tb_fir.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fir;
    import fir_regs_pkg::*;

    localparam int timeout_cycles = 500;
    localparam int pat_depth      = 256;
    localparam int max_len        = 64;

    logic               axis_clk;
    logic               axis_rst_n;
    logic               awvalid;
    logic               wvalid;
    logic [addr_w-1:0]  awaddr;
    logic [reg_w-1:0]   wdata;
    logic               awready;
    logic               wready;
    logic               arvalid;
    logic [addr_w-1:0]  araddr;
    logic               arready;
    logic               rvalid;
    logic               rready;
    logic [reg_w-1:0]   rdata;
    logic               ss_tvalid;
    logic [31:0]        ss_tdata;
    logic               ss_tready;
    logic               sm_tready;
    logic               sm_tvalid;
    logic [31:0]        sm_tdata;
    logic               sm_tlast;

    logic [31:0] pat_mem [pat_depth];
    logic [31:0] coefs [32];
    logic [31:0] samples [max_len];
    logic [31:0] expected [max_len];
    int          in_gap [max_len];
    logic        ready_pat [64];
    int          taps;
    int          len;
    int          seed;

    fir_top dut_i (.*);

    initial axis_clk = 1'b0;
    always #5 axis_clk = ~axis_clk;

    task automatic report_failure();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_wait(input int waited, input string what);
        assert (waited <= timeout_cycles) else begin
            $display("timeout while waiting for %s", what);
            report_failure();
        end
    endtask

    // all drives happen 1 ns after a rising edge
    task automatic write_reg(input logic [addr_w-1:0] addr, input logic [31:0] data);
        int   waited;
        logic fired;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = addr;
        wdata   = data;
        waited  = 0;
        do begin
            @(posedge axis_clk);
            waited++;
            fired = awready && wready;
            #1;
            check_wait(waited, "the write handshake");
        end while (!fired);
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic read_reg(input logic [addr_w-1:0] addr, output logic [31:0] data);
        int   waited;
        logic fired;
        arvalid = 1'b1;
        araddr  = addr;
        waited  = 0;
        do begin
            @(posedge axis_clk);
            waited++;
            fired = arready;
            #1;
            check_wait(waited, "arready");
        end while (!fired);
        arvalid = 1'b0;
        rready  = 1'b1;
        waited  = 0;
        do begin
            @(posedge axis_clk);
            waited++;
            fired = rvalid;
            data  = rdata;
            #1;
            check_wait(waited, "rvalid");
        end while (!fired);
        rready = 1'b0;
    endtask

    task automatic read_check(input string name, input logic [addr_w-1:0] addr,
                              input logic [31:0] exp);
        logic [31:0] value;
        read_reg(addr, value);
        check_value(name, exp, value);
    endtask

    // direct evaluation of the sum rule, history before the run is zero
    task automatic check_model(input string tag);
        logic [31:0] acc;
        for (int n = 0; n < len; n++) begin
            acc = '0;
            for (int k = 0; k < taps; k++) begin
                if (n - k >= 0) begin
                    acc = acc + coefs[k] * samples[n-k];
                end
            end
            check_value($sformatf("%s pattern entry %0d", tag, n), acc, expected[n]);
        end
    endtask

    task automatic send_samples();
        int   waited;
        logic taken;
        for (int n = 0; n < len; n++) begin
            for (int g = 0; g < in_gap[n]; g++) begin
                @(posedge axis_clk);
                #1;
            end
            ss_tvalid = 1'b1;
            ss_tdata  = samples[n];
            waited    = 0;
            do begin
                @(posedge axis_clk);
                waited++;
                taken = ss_tready;
                #1;
                check_wait(waited, "ss_tready");
            end while (!taken);
            ss_tvalid = 1'b0;
        end
    endtask

    task automatic collect_results(input string tag);
        int          waited;
        int          cyc;
        logic        got;
        logic [31:0] data;
        logic        last;
        cyc = 0;
        for (int n = 0; n < len; n++) begin
            waited = 0;
            do begin
                sm_tready = ready_pat[cyc % 64];
                cyc++;
                @(posedge axis_clk);
                waited++;
                got  = sm_tvalid && sm_tready;
                data = sm_tdata;
                last = sm_tlast;
                #1;
                check_wait(waited, "an output result");
            end while (!got);
            check_value($sformatf("%s result %0d", tag, n), expected[n], data);
            check_value($sformatf("%s tlast %0d", tag, n), 32'(n == len - 1), 32'(last));
        end
        sm_tready = 1'b0;
    endtask

    task automatic run_test(input int r, inout int pos);
        string tag;
        tag  = $sformatf("run %0d", r);
        taps = int'(pat_mem[pos]);
        len  = int'(pat_mem[pos+1]);
        pos += 2;
        assert (taps >= 1 && taps <= 32 && len >= 1 && len <= max_len) else begin
            $display("bad run header in the pattern file for %s", tag);
            report_failure();
        end
        for (int k = 0; k < taps; k++) begin
            coefs[k] = pat_mem[pos];
            pos++;
        end
        for (int n = 0; n < len; n++) begin
            samples[n]  = pat_mem[pos];
            expected[n] = pat_mem[pos+1];
            pos += 2;
        end
        check_model(tag);

        write_reg(addr_len, 32'(len));
        write_reg(addr_taps, 32'(taps));
        for (int k = 0; k < taps; k++) begin
            write_reg(addr_coef_lo + addr_w'(k * 4), coefs[k]);
        end
        read_check($sformatf("%s length", tag), addr_len, 32'(len));
        read_check($sformatf("%s taps", tag), addr_taps, 32'(taps));
        for (int k = 0; k < taps; k++) begin
            read_check($sformatf("%s coef %0d", tag, k), addr_coef_lo + addr_w'(k * 4),
                       coefs[k]);
        end

        write_reg(addr_ctrl, 32'h1);
        // config access while running must have no effect
        if (r == 1) begin
            read_check($sformatf("%s busy coef read", tag), addr_coef_lo, bad_read_word);
            write_reg(addr_len, 32'd2);
            write_reg(addr_taps, 32'd1);
            write_reg(addr_coef_lo, 32'h55);
        end

        for (int i = 0; i < max_len; i++) begin
            in_gap[i] = $unsigned($random(seed)) % 3;
        end
        for (int i = 0; i < 64; i++) begin
            ready_pat[i] = ($unsigned($random(seed)) % 4) != 0;
        end
        fork
            send_samples();
            collect_results(tag);
        join

        read_check($sformatf("%s ctrl done", tag), addr_ctrl, 32'h2);
        read_check($sformatf("%s ctrl idle", tag), addr_ctrl, 32'h4);
        assert (!sm_tvalid) else begin
            $display("an extra output appeared after the last result of %s", tag);
            report_failure();
        end
        if (r == 1) begin
            read_check($sformatf("%s length kept", tag), addr_len, 32'(len));
            read_check($sformatf("%s taps kept", tag), addr_taps, 32'(taps));
            read_check($sformatf("%s coef 0 kept", tag), addr_coef_lo, coefs[0]);
        end
    endtask

    initial begin
        int pos;
        int nruns;
        seed       = 32'hff3f;
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        wvalid     = 1'b0;
        awaddr     = '0;
        wdata      = '0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        sm_tready  = 1'b0;
        $readmemh("testbench/fir_patterns.txt", pat_mem);
        repeat (3) @(posedge axis_clk);
        #1;
        axis_rst_n = 1'b1;
        @(posedge axis_clk);
        #1;

        read_check("reset ctrl", addr_ctrl, 32'h4);
        read_check("reset length", addr_len, 32'h0);
        read_check("reset taps", addr_taps, 32'h0);
        read_check("unmapped read", 12'h040, bad_read_word);

        assert (!$isunknown(pat_mem[0])) else begin
            $display("the pattern file could not be read");
            report_failure();
        end
        nruns = int'(pat_mem[0]);
        pos   = 1;
        for (int r = 0; r < nruns; r++) begin
            run_test(r, pos);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/fir_top.sv
`timescale 1ns/1ps
`default_nettype none

module fir_top (
    input  logic                            axis_clk,
    input  logic                            axis_rst_n,
    input  logic                            awvalid,
    input  logic                            wvalid,
    input  logic [fir_regs_pkg::addr_w-1:0] awaddr,
    input  logic [fir_regs_pkg::reg_w-1:0]  wdata,
    output logic                            awready,
    output logic                            wready,
    input  logic                            arvalid,
    input  logic [fir_regs_pkg::addr_w-1:0] araddr,
    output logic                            arready,
    output logic                            rvalid,
    input  logic                            rready,
    output logic [fir_regs_pkg::reg_w-1:0]  rdata,
    input  logic                            ss_tvalid,
    input  logic [fir_core_pkg::data_w-1:0] ss_tdata,
    output logic                            ss_tready,
    input  logic                            sm_tready,
    output logic                            sm_tvalid,
    output logic [fir_core_pkg::data_w-1:0] sm_tdata,
    output logic                            sm_tlast
);
    import fir_regs_pkg::*;
    import fir_core_pkg::*;

    logic              start_pulse;
    logic              running;
    logic              run_done;
    logic              sample_ready;
    logic              sample_take;
    tap_cnt_t          tap_num;
    tap_idx_t          coef_idx;
    tap_idx_t          age_idx;
    logic [reg_w-1:0]  data_length;
    logic [data_w-1:0] coef;
    logic [data_w-1:0] hist_sample;

    // configuration and coefficients
    fir_axil_regs regs_i (
        .axis_clk, .axis_rst_n,
        .awvalid, .wvalid, .awaddr, .wdata, .awready, .wready,
        .arvalid, .araddr, .arready, .rvalid, .rready, .rdata,
        .run_done, .coef_idx, .start_pulse, .running,
        .tap_num, .data_length, .coef
    );

    // input samples
    fir_sample_history hist_i (
        .axis_clk, .axis_rst_n,
        .ss_tvalid, .ss_tdata, .ss_tready,
        .start_pulse, .running, .sample_take, .age_idx,
        .sample_ready, .hist_sample
    );

    fir_mac_engine mac_i (
        .axis_clk, .axis_rst_n,
        .start_pulse, .tap_num, .data_length,
        .sample_ready, .sample_take, .age_idx, .coef_idx,
        .hist_sample, .coef,
        .sm_tready, .sm_tvalid, .sm_tdata, .sm_tlast, .run_done
    );

endmodule

`default_nettype wire

// File: hw/fir_mac_engine.sv
`timescale 1ns/1ps
`default_nettype none

module fir_mac_engine (
    input  logic                            axis_clk,
    input  logic                            axis_rst_n,
    input  logic                            start_pulse,
    input  fir_core_pkg::tap_cnt_t          tap_num,
    input  logic [fir_regs_pkg::reg_w-1:0]  data_length,
    input  logic                            sample_ready,
    output logic                            sample_take,
    output fir_core_pkg::tap_idx_t          age_idx,
    output fir_core_pkg::tap_idx_t          coef_idx,
    input  logic [fir_core_pkg::data_w-1:0] hist_sample,
    input  logic [fir_core_pkg::data_w-1:0] coef,
    input  logic                            sm_tready,
    output logic                            sm_tvalid,
    output logic [fir_core_pkg::data_w-1:0] sm_tdata,
    output logic                            sm_tlast,
    output logic                            run_done
);
    import fir_core_pkg::*;

    tap_idx_t                       idx;
    logic                           busy;
    logic                           last_tap;
    logic                           mul_vld;
    logic                           mul_last;
    logic [data_w-1:0]              mul;
    logic [data_w-1:0]              acc;
    logic [$bits(data_length)-1:0]  out_cnt;
    logic                           out_fire;

    // next sample only once the pipeline and the output are empty
    assign sample_take = sample_ready && !busy && !mul_vld && !sm_tvalid;

    assign age_idx  = idx;
    assign coef_idx = idx;
    assign last_tap = (tap_cnt_t'(idx) + tap_cnt_t'(1)) >= tap_num;

    assign out_fire = sm_tvalid && sm_tready;
    assign run_done = out_fire && sm_tlast;

    // tap sequencer
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            busy <= 1'b0;
            idx  <= '0;
        end else if (sample_take) begin
            busy <= 1'b1;
            idx  <= '0;
        end else if (busy) begin
            if (last_tap) begin
                busy <= 1'b0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    // product stage, zero taps gives a zero result
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            mul_vld  <= 1'b0;
            mul_last <= 1'b0;
        end else begin
            mul_vld  <= busy;
            mul_last <= busy && last_tap;
        end
    end

    always_ff @(posedge axis_clk) begin
        mul <= (tap_num != '0) ? hist_sample * coef : '0;
    end

    always_ff @(posedge axis_clk) begin
        if (sample_take) begin
            acc <= '0;
        end else if (mul_vld) begin
            acc <= acc + mul;
        end
    end

    // output register, held until accepted
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
            sm_tdata  <= '0;
            out_cnt   <= '0;
        end else if (start_pulse) begin
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
            out_cnt   <= '0;
        end else if (mul_vld && mul_last) begin
            sm_tvalid <= 1'b1;
            sm_tdata  <= acc + mul;
            sm_tlast  <= (out_cnt + 1'b1) == data_length;
        end else if (out_fire) begin
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
            out_cnt   <= out_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/fir_sample_history.sv
`timescale 1ns/1ps
`default_nettype none

module fir_sample_history (
    input  logic                            axis_clk,
    input  logic                            axis_rst_n,
    input  logic                            ss_tvalid,
    input  logic [fir_core_pkg::data_w-1:0] ss_tdata,
    output logic                            ss_tready,
    input  logic                            start_pulse,
    input  logic                            running,
    input  logic                            sample_take,
    input  fir_core_pkg::tap_idx_t          age_idx,
    output logic                            sample_ready,
    output logic [fir_core_pkg::data_w-1:0] hist_sample
);
    import fir_core_pkg::*;

    logic [data_w-1:0] hist_mem [max_taps];
    logic [data_w-1:0] pend_data;
    tap_idx_t          wr_ptr;
    tap_idx_t          wr_next;
    tap_idx_t          rd_ptr;
    logic              pending;
    logic              push;

    // one fresh sample at a time and none while the history clears
    assign ss_tready    = running && !pending && !start_pulse;
    assign push         = ss_tvalid && ss_tready;
    assign sample_ready = pending;

    // wr_ptr marks the newest entry so age 0 reads it back
    assign wr_next     = wr_ptr + 1'b1;
    assign rd_ptr      = wr_ptr - age_idx;
    assign hist_sample = hist_mem[rd_ptr];

    // fresh sample waits here until the engine starts on it
    always_ff @(posedge axis_clk) begin
        if (push) begin
            pend_data <= ss_tdata;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (start_pulse) begin
            for (int i = 0; i < max_taps; i++) begin
                hist_mem[i] <= '0;
            end
        end else if (sample_take) begin
            hist_mem[wr_next] <= pend_data;
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            wr_ptr  <= '0;
            pending <= 1'b0;
        end else if (start_pulse) begin
            wr_ptr  <= '0;
            pending <= 1'b0;
        end else if (push) begin
            pending <= 1'b1;
        end else if (sample_take) begin
            wr_ptr  <= wr_next;
            pending <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hw/fir_axil_regs.sv
`timescale 1ns/1ps
`default_nettype none

module fir_axil_regs (
    input  logic                            axis_clk,
    input  logic                            axis_rst_n,
    input  logic                            awvalid,
    input  logic                            wvalid,
    input  logic [fir_regs_pkg::addr_w-1:0] awaddr,
    input  logic [fir_regs_pkg::reg_w-1:0]  wdata,
    output logic                            awready,
    output logic                            wready,
    input  logic                            arvalid,
    input  logic [fir_regs_pkg::addr_w-1:0] araddr,
    output logic                            arready,
    output logic                            rvalid,
    input  logic                            rready,
    output logic [fir_regs_pkg::reg_w-1:0]  rdata,
    input  logic                            run_done,
    input  fir_core_pkg::tap_idx_t          coef_idx,
    output logic                            start_pulse,
    output logic                            running,
    output fir_core_pkg::tap_cnt_t          tap_num,
    output logic [fir_regs_pkg::reg_w-1:0]  data_length,
    output logic [fir_core_pkg::data_w-1:0] coef
);
    import fir_regs_pkg::*;
    import fir_core_pkg::*;

    logic [1:0]        state;
    logic              idle;
    logic              wr_fire;
    logic              cfg_wr;
    logic              start_wr;
    logic              ctrl_rd_done;
    ap_ctrl_u          wr_ctrl;
    ap_ctrl_u          rd_ctrl;
    logic [addr_w-1:0] rd_addr;
    logic [data_w-1:0] coef_mem [max_taps];

    function automatic logic is_coef_addr(input logic [addr_w-1:0] a);
        return (a >= addr_coef_lo) && (a <= addr_coef_hi);
    endfunction

    assign idle    = (state == st_idle);
    assign running = (state == st_calc);

    // write lands on the single cycle both readies are up
    assign wr_fire      = awready && wready;
    assign cfg_wr       = wr_fire && idle;
    assign wr_ctrl.raw  = wdata;
    assign start_wr     = cfg_wr && (awaddr == addr_ctrl) && wr_ctrl.f.start;
    assign ctrl_rd_done = rvalid && rready && (rd_addr == addr_ctrl);

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            awready <= awvalid && wvalid && !wready;
            wready  <= awvalid && wvalid && !wready;
            arready <= arvalid && !arready && !rvalid;
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end else if (arvalid && arready) begin
                rvalid <= 1'b1;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (arvalid && arready) begin
            rd_addr <= araddr;
        end
    end

    // idle -> calc -> done -> idle
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state       <= st_idle;
            start_pulse <= 1'b0;
        end else begin
            start_pulse <= start_wr;
            case (state)
                st_idle: if (start_wr) state <= st_calc;
                st_calc: if (run_done) state <= st_done;
                st_done: if (ctrl_rd_done) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            data_length <= '0;
            tap_num     <= '0;
        end else if (cfg_wr) begin
            if (awaddr == addr_len) begin
                data_length <= wdata;
            end
            // counts above the bank size saturate
            if (awaddr == addr_taps) begin
                tap_num <= (wdata > max_taps) ? tap_cnt_t'(max_taps) : tap_cnt_t'(wdata);
            end
        end
    end

    // coefficient bank, one word per 4-byte slot
    always_ff @(posedge axis_clk) begin
        if (cfg_wr && is_coef_addr(awaddr)) begin
            coef_mem[tap_idx_t'(awaddr[6:2])] <= wdata;
        end
    end

    assign coef = coef_mem[coef_idx];

    always_comb begin
        rd_ctrl.raw     = '0;
        rd_ctrl.f.start = start_pulse;
        rd_ctrl.f.done  = (state == st_done);
        rd_ctrl.f.idle  = idle;
        if (rd_addr == addr_ctrl) begin
            rdata = rd_ctrl.raw;
        end else if (rd_addr == addr_len) begin
            rdata = data_length;
        end else if (rd_addr == addr_taps) begin
            rdata = reg_w'(tap_num);
        end else if (is_coef_addr(rd_addr) && idle) begin
            rdata = coef_mem[tap_idx_t'(rd_addr[6:2])];
        end else begin
            rdata = bad_read_word;
        end
    end

endmodule

`default_nettype wire

// File: hw/fir_core_pkg.sv
`default_nettype none

package fir_core_pkg;

    // sample, coefficient and result width
    localparam int data_w = 32;

    // depth of the coefficient bank and sample history
    localparam int max_taps = 32;

    // index over taps, also used as sample age
    typedef logic [$clog2(max_taps)-1:0] tap_idx_t;

    // tap count, 0 up to max_taps inclusive
    typedef logic [$clog2(max_taps):0] tap_cnt_t;

endpackage

`default_nettype wire

// File: hw/fir_regs_pkg.sv
`default_nettype none

package fir_regs_pkg;

    localparam int addr_w = 12;
    localparam int reg_w  = 32;

    // register map
    localparam logic [addr_w-1:0] addr_ctrl    = 12'h000;
    localparam logic [addr_w-1:0] addr_len     = 12'h010;
    localparam logic [addr_w-1:0] addr_taps    = 12'h014;
    localparam logic [addr_w-1:0] addr_coef_lo = 12'h080;
    localparam logic [addr_w-1:0] addr_coef_hi = 12'h0ff;

    localparam logic [reg_w-1:0] bad_read_word = '1;

    // run state encoding
    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_calc = 2'd1;
    localparam logic [1:0] st_done = 2'd2;

    // control word, raw bus view or decoded fields
    typedef union packed {
        logic [reg_w-1:0] raw;
        struct packed {
            logic [reg_w-4:0] rsvd;
            logic             idle;
            logic             done;
            logic             start;
        } f;
    } ap_ctrl_u;

endpackage

`default_nettype wire
